// ==== all.f ====
+incdir+verif
design/xpu_pkg.sv
design/xpu_wb_regs.sv
design/tsf_timer.sv
design/phy_rx_parse.sv
design/pkt_filter.sv
design/xpu_top.sv
verif/tb_xpu.sv

// ==== design/phy_rx_parse.sv ====
// first rx stage, collects demodulated header bytes into frame control and addr1..addr3
`timescale 1ns/1ps
`default_nettype none

module phy_rx_parse (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  xpu_pkg::xpu_cfg_t      cfg_i,
    input  logic                   pkt_header_valid_strobe_i,
    input  logic                   byte_in_strobe_i,
    input  xpu_pkg::rx_byte_t      rx_byte_i,
    output xpu_pkg::rx_hdr_t       hdr_o,
    output xpu_pkg::rx_hdr_valid_t hdr_valid_o
);
    import xpu_pkg::*;

    // new frame or sw reset wipes the header
    logic       clr;
    // byte lane inside each field
    logic [2:0] lane_fc;
    logic [2:0] lane_a1;
    logic [2:0] lane_a2;
    logic [2:0] lane_a3;

    assign clr = pkt_header_valid_strobe_i | cfg_i.rx_soft_rst;

    assign lane_fc = 3'(rx_byte_i.idx - 16'(HDR_FC_FIRST));
    assign lane_a1 = 3'(rx_byte_i.idx - 16'(HDR_ADDR1_FIRST));
    assign lane_a2 = 3'(rx_byte_i.idx - 16'(HDR_ADDR2_FIRST));
    assign lane_a3 = 3'(rx_byte_i.idx - 16'(HDR_ADDR3_FIRST));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hdr_o       <= '0;
            hdr_valid_o <= '0;
        end else if (clr) begin
            hdr_o       <= '0;
            hdr_valid_o <= '0;
        end else if (byte_in_strobe_i) begin
            // steer byte into its field, lsb first
            if (rx_byte_i.idx <= HDR_FC_LAST) begin
                hdr_o.fc[8*lane_fc +: 8] <= rx_byte_i.data;
            end else if (rx_byte_i.idx <= HDR_ADDR1_LAST) begin
                hdr_o.addr1[8*lane_a1 +: 8] <= rx_byte_i.data;
            end else if (rx_byte_i.idx <= HDR_ADDR2_LAST) begin
                hdr_o.addr2[8*lane_a2 +: 8] <= rx_byte_i.data;
            end else if (rx_byte_i.idx <= HDR_ADDR3_LAST) begin
                hdr_o.addr3[8*lane_a3 +: 8] <= rx_byte_i.data;
            end
            // sequence control and beyond are not kept

            // flags set on the last byte of each field
            if (rx_byte_i.idx == HDR_FC_LAST) begin
                hdr_valid_o.fc <= 1'b1;
            end
            if (rx_byte_i.idx == HDR_ADDR1_LAST) begin
                hdr_valid_o.addr1 <= 1'b1;
            end
            if (rx_byte_i.idx == HDR_ADDR2_LAST) begin
                hdr_valid_o.addr2 <= 1'b1;
            end
            if (rx_byte_i.idx == HDR_ADDR3_LAST) begin
                hdr_valid_o.addr3 <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/pkt_filter.sv ====
// second rx stage, decides whether the frame is kept away from dma once addr1 is known
`timescale 1ns/1ps
`default_nettype none

module pkt_filter (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  xpu_pkg::xpu_cfg_t      cfg_i,
    input  logic                   pkt_header_valid_strobe_i,
    input  xpu_pkg::rx_hdr_t       hdr_i,
    input  xpu_pkg::rx_hdr_valid_t hdr_valid_i,
    output logic                   block_rx_dma_o,
    output logic                   block_rx_dma_valid_o
);
    import xpu_pkg::*;

    logic clr;
    // previous addr1 flag, for edge detect
    logic addr1_vld_q;
    logic addr1_rise;
    logic is_self;
    logic is_bcast;
    logic is_mgmt;
    logic pass;

    assign clr        = pkt_header_valid_strobe_i | cfg_i.rx_soft_rst;
    assign addr1_rise = hdr_valid_i.addr1 & ~addr1_vld_q;

    // match terms
    assign is_self  = (hdr_i.addr1 == cfg_i.self_mac);
    assign is_bcast = &hdr_i.addr1;
    // fc is already valid by the time addr1 completes
    assign is_mgmt  = (hdr_i.fc.ftype == FC_TYPE_MGMT);

    assign pass = cfg_i.filter_cfg[FILT_PASS_ALL]
                | is_self
                | (is_bcast & cfg_i.filter_cfg[FILT_PASS_BCAST])
                | (is_mgmt & cfg_i.filter_cfg[FILT_PASS_MGMT]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr1_vld_q          <= 1'b0;
            block_rx_dma_o       <= 1'b0;
            block_rx_dma_valid_o <= 1'b0;
        end else if (clr) begin
            addr1_vld_q          <= 1'b0;
            block_rx_dma_o       <= 1'b0;
            block_rx_dma_valid_o <= 1'b0;
        end else begin
            addr1_vld_q <= hdr_valid_i.addr1;
            // decision held until next frame
            if (addr1_rise) begin
                block_rx_dma_o       <= ~pass;
                block_rx_dma_valid_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tsf_timer.sv ====
// 64-bit tsf counter advancing on a 1 us tick, loadable from the register file
`timescale 1ns/1ps
`default_nettype none

module tsf_timer (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  xpu_pkg::xpu_cfg_t cfg_i,
    output xpu_pkg::tsf_t     tsf_runtime_val_o,
    output logic              tsf_pulse_1m_o
);
    import xpu_pkg::*;

    // clock divider for the microsecond tick
    logic [TICK_CNT_W-1:0] div_cnt;
    logic                  div_wrap;

    assign div_wrap = (div_cnt == TICK_CNT_W'(CLKS_PER_US - 1));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt           <= '0;
            tsf_pulse_1m_o    <= 1'b0;
            tsf_runtime_val_o <= '0;
        end else if (cfg_i.tsf_load) begin
            // load restarts the tick phase too
            div_cnt           <= '0;
            tsf_pulse_1m_o    <= 1'b0;
            tsf_runtime_val_o <= cfg_i.tsf_load_val;
        end else begin
            if (div_wrap) begin
                div_cnt        <= '0;
                tsf_pulse_1m_o <= 1'b1;
            end else begin
                div_cnt        <= div_cnt + 1'b1;
                tsf_pulse_1m_o <= 1'b0;
            end
            // count follows the pulse by one edge
            if (tsf_pulse_1m_o) begin
                tsf_runtime_val_o <= tsf_runtime_val_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/xpu_pkg.sv ====
// shared widths, register map and header/config types of the rx MAC helper core, compile first
`default_nettype none

package xpu_pkg;

    // bus and datapath widths
    localparam int WB_DATA_W  = 32;
    localparam int WB_ADR_W   = 6;
    localparam int WB_SEL_W   = WB_DATA_W / 8;
    localparam int TSF_W      = 64;
    localparam int MAC_W      = 48;
    localparam int FILT_CFG_W = 3;

    // 1 us tick derived from the core clock
    localparam int CLKS_PER_US = 100;
    localparam int TICK_CNT_W  = $clog2(CLKS_PER_US);

    // register word indices
    localparam logic [WB_ADR_W-1:0] REG_CTRL        = 6'd0;
    localparam logic [WB_ADR_W-1:0] REG_TSF_LOAD_LO = 6'd2;
    // write to this one fires the tsf load
    localparam logic [WB_ADR_W-1:0] REG_TSF_LOAD_HI = 6'd3;
    localparam logic [WB_ADR_W-1:0] REG_FILTER_CFG  = 6'd27;
    localparam logic [WB_ADR_W-1:0] REG_MAC_LO      = 6'd30;
    localparam logic [WB_ADR_W-1:0] REG_MAC_HI      = 6'd31;
    // read only
    localparam logic [WB_ADR_W-1:0] REG_TSF_RT_LO   = 6'd58;
    localparam logic [WB_ADR_W-1:0] REG_TSF_RT_HI   = 6'd59;
    localparam logic [WB_ADR_W-1:0] REG_GIT_REV     = 6'd63;

    // control and filter bit positions
    localparam int CTRL_RX_SOFT_RST = 0;
    localparam int FILT_PASS_ALL    = 0;
    localparam int FILT_PASS_BCAST  = 1;
    localparam int FILT_PASS_MGMT   = 2;

    // 802.11 frame type code
    localparam logic [1:0] FC_TYPE_MGMT = 2'd0;

    // header byte positions, each field little-endian
    localparam int HDR_FC_FIRST    = 0;
    localparam int HDR_FC_LAST     = 3;
    localparam int HDR_ADDR1_FIRST = 4;
    localparam int HDR_ADDR1_LAST  = 9;
    localparam int HDR_ADDR2_FIRST = 10;
    localparam int HDR_ADDR2_LAST  = 15;
    localparam int HDR_ADDR3_FIRST = 16;
    localparam int HDR_ADDR3_LAST  = 21;

    typedef logic [MAC_W-1:0] mac_addr_t;
    typedef logic [TSF_W-1:0] tsf_t;

    // frame control word plus duration, as received
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  subtype;
        logic [1:0]  ftype;
        logic [1:0]  version;
    } frame_ctl_t;

    // one demodulated byte with its position in the psdu
    typedef struct packed {
        logic [15:0] idx;
        logic [7:0]  data;
    } rx_byte_t;

    typedef struct packed {
        frame_ctl_t fc;
        mac_addr_t  addr1;
        mac_addr_t  addr2;
        mac_addr_t  addr3;
    } rx_hdr_t;

    typedef struct packed {
        logic fc;
        logic addr1;
        logic addr2;
        logic addr3;
    } rx_hdr_valid_t;

    // register contents fanned out to the stages
    typedef struct packed {
        logic                  rx_soft_rst;
        logic [FILT_CFG_W-1:0] filter_cfg;
        mac_addr_t             self_mac;
        tsf_t                  tsf_load_val;
        logic                  tsf_load;
    } xpu_cfg_t;

endpackage

`default_nettype wire

// ==== design/xpu_top.sv ====
// rx MAC helper top, wires register file and tsf timer beside the parse/filter pipeline
`timescale 1ns/1ps
`default_nettype none

module xpu_top (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    // wishbone slave
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [xpu_pkg::WB_ADR_W-1:0]   wb_adr_i,
    input  logic [xpu_pkg::WB_DATA_W-1:0]  wb_dat_i,
    input  logic [xpu_pkg::WB_SEL_W-1:0]   wb_sel_i,
    output logic [xpu_pkg::WB_DATA_W-1:0]  wb_dat_o,
    output logic                           wb_ack_o,
    input  logic [xpu_pkg::WB_DATA_W-1:0]  git_rev_i,
    // from the demodulator
    input  logic                           pkt_header_valid_strobe_i,
    input  logic                           byte_in_strobe_i,
    input  xpu_pkg::rx_byte_t              rx_byte_i,
    // status out
    output xpu_pkg::tsf_t                  tsf_runtime_val_o,
    output logic                           tsf_pulse_1m_o,
    output xpu_pkg::mac_addr_t             mac_addr_o,
    output xpu_pkg::rx_hdr_t               hdr_o,
    output xpu_pkg::rx_hdr_valid_t         hdr_valid_o,
    output logic                           block_rx_dma_o,
    output logic                           block_rx_dma_valid_o
);
    import xpu_pkg::*;

    // register contents to all stages
    xpu_cfg_t cfg;

    assign mac_addr_o = cfg.self_mac;

    xpu_wb_regs u_xpu_wb_regs (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_sel_i          (wb_sel_i),
        .tsf_runtime_val_i (tsf_runtime_val_o),
        .git_rev_i         (git_rev_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .cfg_o             (cfg)
    );

    tsf_timer u_tsf_timer (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .cfg_i             (cfg),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1m_o    (tsf_pulse_1m_o)
    );

    // rx pipeline, parse then filter
    phy_rx_parse u_phy_rx_parse (
        .clk_i                     (clk_i),
        .arst_n_i                  (arst_n_i),
        .cfg_i                     (cfg),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .rx_byte_i                 (rx_byte_i),
        .hdr_o                     (hdr_o),
        .hdr_valid_o               (hdr_valid_o)
    );

    pkt_filter u_pkt_filter (
        .clk_i                     (clk_i),
        .arst_n_i                  (arst_n_i),
        .cfg_i                     (cfg),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .hdr_i                     (hdr_o),
        .hdr_valid_i               (hdr_valid_o),
        .block_rx_dma_o            (block_rx_dma_o),
        .block_rx_dma_valid_o      (block_rx_dma_valid_o)
    );

endmodule

`default_nettype wire

// ==== design/xpu_wb_regs.sv ====
// wishbone classic register file, drives the config struct and muxes tsf/revision read-back
`timescale 1ns/1ps
`default_nettype none

module xpu_wb_regs (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [xpu_pkg::WB_ADR_W-1:0]   wb_adr_i,
    input  logic [xpu_pkg::WB_DATA_W-1:0]  wb_dat_i,
    input  logic [xpu_pkg::WB_SEL_W-1:0]   wb_sel_i,
    input  xpu_pkg::tsf_t                  tsf_runtime_val_i,
    input  logic [xpu_pkg::WB_DATA_W-1:0]  git_rev_i,
    output logic [xpu_pkg::WB_DATA_W-1:0]  wb_dat_o,
    output logic                           wb_ack_o,
    output xpu_pkg::xpu_cfg_t              cfg_o
);
    import xpu_pkg::*;

    // new request, not yet acked
    logic                 wb_req;
    logic                 wb_wr;
    logic [WB_DATA_W-1:0] rd_data;

    logic [WB_DATA_W-1:0] ctrl_q;
    logic [WB_DATA_W-1:0] tsf_load_lo_q;
    logic [WB_DATA_W-1:0] tsf_load_hi_q;
    logic [WB_DATA_W-1:0] filter_cfg_q;
    logic [WB_DATA_W-1:0] mac_lo_q;
    logic [WB_DATA_W-1:0] mac_hi_q;
    logic                 tsf_load_q;

    // only lanes with sel set take the new byte
    function automatic logic [WB_DATA_W-1:0] sel_merge(
        input logic [WB_DATA_W-1:0] cur,
        input logic [WB_DATA_W-1:0] nxt,
        input logic [WB_SEL_W-1:0]  sel
    );
        logic [WB_DATA_W-1:0] res;
        res = cur;
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = nxt[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wb_wr  = wb_req & wb_we_i;

    // ack one cycle after the request is seen, write on the same edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o      <= 1'b0;
            tsf_load_q    <= 1'b0;
            ctrl_q        <= '0;
            tsf_load_lo_q <= '0;
            tsf_load_hi_q <= '0;
            filter_cfg_q  <= '0;
            mac_lo_q      <= '0;
            mac_hi_q      <= '0;
        end else begin
            wb_ack_o   <= wb_req;
            // strobe lands in the cycle after the hi word write
            tsf_load_q <= wb_wr && (wb_adr_i == REG_TSF_LOAD_HI);
            if (wb_wr) begin
                case (wb_adr_i)
                    REG_CTRL:        ctrl_q <= sel_merge(ctrl_q, wb_dat_i, wb_sel_i);
                    REG_TSF_LOAD_LO: tsf_load_lo_q <= sel_merge(tsf_load_lo_q, wb_dat_i, wb_sel_i);
                    REG_TSF_LOAD_HI: tsf_load_hi_q <= sel_merge(tsf_load_hi_q, wb_dat_i, wb_sel_i);
                    REG_FILTER_CFG:  filter_cfg_q <= sel_merge(filter_cfg_q, wb_dat_i, wb_sel_i);
                    REG_MAC_LO:      mac_lo_q <= sel_merge(mac_lo_q, wb_dat_i, wb_sel_i);
                    REG_MAC_HI:      mac_hi_q <= sel_merge(mac_hi_q, wb_dat_i, wb_sel_i);
                    // read only and unmapped words drop the write
                    default: ;
                endcase
            end
        end
    end

    // read-back mux, unmapped reads give zero
    always_comb begin
        case (wb_adr_i)
            REG_CTRL:        rd_data = ctrl_q;
            REG_TSF_LOAD_LO: rd_data = tsf_load_lo_q;
            REG_TSF_LOAD_HI: rd_data = tsf_load_hi_q;
            REG_FILTER_CFG:  rd_data = filter_cfg_q;
            REG_MAC_LO:      rd_data = mac_lo_q;
            REG_MAC_HI:      rd_data = mac_hi_q;
            REG_TSF_RT_LO:   rd_data = tsf_runtime_val_i[WB_DATA_W-1:0];
            REG_TSF_RT_HI:   rd_data = tsf_runtime_val_i[TSF_W-1:WB_DATA_W];
            REG_GIT_REV:     rd_data = git_rev_i;
            default:         rd_data = '0;
        endcase
    end

    // read data held for the ack cycle
    always_ff @(posedge clk_i) begin
        if (wb_req) begin
            wb_dat_o <= rd_data;
        end
    end

    always_comb begin
        cfg_o.rx_soft_rst  = ctrl_q[CTRL_RX_SOFT_RST];
        cfg_o.filter_cfg   = filter_cfg_q[FILT_CFG_W-1:0];
        // only low half of the hi word carries address bits
        cfg_o.self_mac     = {mac_hi_q[MAC_W-WB_DATA_W-1:0], mac_lo_q};
        cfg_o.tsf_load_val = {tsf_load_hi_q, tsf_load_lo_q};
        cfg_o.tsf_load     = tsf_load_q;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the xpu testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_xpu -f all.f
# a fatal stop exits non-zero, so the log decides the result
./obj_dir/Vtb_xpu > sim.log 2>&1 || true
cat sim.log
if grep -qF 'Test failures found' sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -qF 'All tests passed!' sim.log; then
    echo "simulation ended without reaching the end of the test sequence"
    exit 1
fi
echo "simulation passed"

// ==== verif/xpu_checks.svh ====
// compare tasks, timed waits and frame builders included inside the tb_xpu module body
`ifndef XPU_CHECKS_SVH
`define XPU_CHECKS_SVH

// signals a wait can watch
typedef enum int {SIG_ACK, SIG_PULSE, SIG_FC, SIG_ADDR1, SIG_ADDR2, SIG_ADDR3,
                  SIG_DECISION} watch_t;

function automatic logic probe(input watch_t which);
    case (which)
        SIG_ACK:   return wb_ack_o;
        SIG_PULSE: return tsf_pulse_1m_o;
        SIG_FC:    return hdr_valid_o.fc;
        SIG_ADDR1: return hdr_valid_o.addr1;
        SIG_ADDR2: return hdr_valid_o.addr2;
        SIG_ADDR3: return hdr_valid_o.addr3;
        default:   return block_rx_dma_valid_o;
    endcase
endfunction

// polls on falling edges and gives up after limit cycles
task automatic wait_high(input watch_t which, input int limit);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!probe(which)) begin
        n++;
        if (n > limit) begin
            abort_run($sformatf("timeout after %0d cycles waiting for %s", limit, which.name()));
        end
        @(negedge clk_i);
    end
endtask

task automatic check_data(input string name, input logic [WB_DATA_W-1:0] got, exp);
    if (got !== exp) begin
        abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_tsf(input string name, input tsf_t got, exp);
    if (got !== exp) begin
        abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_mac(input string name, input mac_addr_t got, exp);
    if (got !== exp) begin
        abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_fc(input string name, input frame_ctl_t got, exp);
    if (got !== exp) begin
        abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
        abort_run($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
    end
endtask

// clock cycle counts between events
task automatic check_count(input string name, input int got, exp);
    if (got != exp) begin
        abort_run($sformatf("error at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
endtask

// field value from its bytes with the first byte least significant
function automatic logic [63:0] field_le(input int first, input int last);
    logic [63:0] v;
    v = '0;
    for (int i = last; i >= first; i--) begin
        v = {v[55:0], frame_bytes[i]};
    end
    return v;
endfunction

task automatic fill_frame(input logic [1:0] ftype);
    for (int i = 0; i < 22; i++) begin
        frame_bytes[i] = 8'($random(seed));
    end
    // type lives in bits 3:2 of the first fc byte
    frame_bytes[0][3:2] = ftype;
endtask

task automatic set_addr1(input mac_addr_t a);
    for (int i = 0; i < 6; i++) begin
        frame_bytes[4 + i] = a[8*i +: 8];
    end
endtask

`endif

// ==== verif/tb_xpu.sv ====
// directed testbench for the rx MAC helper top that all.f builds and run.sh runs
`timescale 1ns/1ps
`default_nettype none

module tb_xpu;
    import xpu_pkg::*;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 wb_cyc_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    logic [WB_ADR_W-1:0]  wb_adr_i;
    logic [WB_DATA_W-1:0] wb_dat_i;
    logic [WB_SEL_W-1:0]  wb_sel_i;
    logic [WB_DATA_W-1:0] wb_dat_o;
    logic                 wb_ack_o;
    logic [WB_DATA_W-1:0] git_rev_i;
    logic                 pkt_header_valid_strobe_i;
    logic                 byte_in_strobe_i;
    rx_byte_t             rx_byte_i;
    tsf_t                 tsf_runtime_val_o;
    logic                 tsf_pulse_1m_o;
    mac_addr_t            mac_addr_o;
    rx_hdr_t              hdr_o;
    rx_hdr_valid_t        hdr_valid_o;
    logic                 block_rx_dma_o;
    logic                 block_rx_dma_valid_o;

    // header bytes of the frame being sent by psdu byte position
    logic [7:0] frame_bytes [22];
    int         seed;
    mac_addr_t  own_mac;

    xpu_top u_xpu_top (
        .clk_i                     (clk_i),
        .arst_n_i                  (arst_n_i),
        .wb_cyc_i                  (wb_cyc_i),
        .wb_stb_i                  (wb_stb_i),
        .wb_we_i                   (wb_we_i),
        .wb_adr_i                  (wb_adr_i),
        .wb_dat_i                  (wb_dat_i),
        .wb_sel_i                  (wb_sel_i),
        .wb_dat_o                  (wb_dat_o),
        .wb_ack_o                  (wb_ack_o),
        .git_rev_i                 (git_rev_i),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .rx_byte_i                 (rx_byte_i),
        .tsf_runtime_val_o         (tsf_runtime_val_o),
        .tsf_pulse_1m_o            (tsf_pulse_1m_o),
        .mac_addr_o                (mac_addr_o),
        .hdr_o                     (hdr_o),
        .hdr_valid_o               (hdr_valid_o),
        .block_rx_dma_o            (block_rx_dma_o),
        .block_rx_dma_valid_o      (block_rx_dma_valid_o)
    );

    // 8 ns period
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    `include "xpu_checks.svh"

    // request held until ack and dropped on the next rising edge
    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat,
                            input logic [WB_SEL_W-1:0] sel);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        wait_high(SIG_ACK, 4);
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        // ack lasts a single cycle
        @(negedge clk_i);
        check_flag("wb_ack_o", wb_ack_o, 1'b0);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DATA_W-1:0] dat);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        wait_high(SIG_ACK, 4);
        // dat_o valid while ack is high
        dat = wb_dat_o;
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        // ack lasts a single cycle
        @(negedge clk_i);
        check_flag("wb_ack_o", wb_ack_o, 1'b0);
    endtask

    task automatic send_hdr_strobe();
        @(posedge clk_i);
        pkt_header_valid_strobe_i <= 1'b1;
        @(posedge clk_i);
        pkt_header_valid_strobe_i <= 1'b0;
    endtask

    // back to back byte strobes at one per clock
    task automatic send_bytes(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(posedge clk_i);
            byte_in_strobe_i <= 1'b1;
            rx_byte_i        <= {16'(i), frame_bytes[i]};
        end
        @(posedge clk_i);
        byte_in_strobe_i <= 1'b0;
    endtask

    // flags and decision must stay down for a few idle cycles
    task automatic check_cleared();
        repeat (4) begin
            @(negedge clk_i);
            check_flag("hdr_valid_o", |hdr_valid_o, 1'b0);
            check_flag("block_rx_dma_valid_o", block_rx_dma_valid_o, 1'b0);
        end
    endtask

    task automatic test_registers();
        logic [WB_DATA_W-1:0] rd;
        wb_write(REG_FILTER_CFG, 32'h0000_0005, 4'hf);
        wb_write(REG_MAC_LO, 32'hc0ff_ee11, 4'hf);
        wb_read(REG_FILTER_CFG, rd);
        check_data("wb_dat_o filter_cfg", rd, 32'h0000_0005);
        wb_read(REG_MAC_LO, rd);
        check_data("wb_dat_o mac_lo", rd, 32'hc0ff_ee11);
        // only byte lanes 1 and 2 change
        wb_write(REG_MAC_LO, 32'h1234_5678, 4'b0110);
        wb_read(REG_MAC_LO, rd);
        check_data("wb_dat_o mac_lo partial", rd, 32'hc034_5611);
        wb_read(6'd40, rd);
        check_data("wb_dat_o unmapped", rd, 32'h0);
        wb_read(REG_GIT_REV, rd);
        check_data("wb_dat_o git_rev", rd, git_rev_i);
    endtask

    task automatic test_mac_output();
        wb_write(REG_MAC_LO, own_mac[31:0], 4'hf);
        // upper half of the hi word is not part of the address
        wb_write(REG_MAC_HI, {16'hdead, own_mac[47:32]}, 4'hf);
        @(negedge clk_i);
        check_mac("mac_addr_o", mac_addr_o, own_mac);
    endtask

    task automatic test_tsf();
        tsf_t                 v;
        logic [WB_DATA_W-1:0] rd;
        time                  last_pulse;
        int                   gap;
        // low word close to wrap so the carry into the hi word is seen
        v = 64'h0000_0a5c_ffff_fff0;
        wb_write(REG_TSF_LOAD_LO, v[31:0], 4'hf);
        wb_write(REG_TSF_LOAD_HI, v[63:32], 4'hf);
        wb_read(REG_TSF_RT_LO, rd);
        check_data("wb_dat_o tsf_rt_lo", rd, v[31:0]);
        wb_read(REG_TSF_RT_HI, rd);
        check_data("wb_dat_o tsf_rt_hi", rd, v[63:32]);
        for (int k = 1; k <= 20; k++) begin
            wait_high(SIG_PULSE, 2 * CLKS_PER_US);
            // pulses come CLKS_PER_US clocks of 8 ns apart
            if (k > 1) begin
                gap = int'(($time - last_pulse) / 8);
                check_count("tsf_pulse_1m_o period", gap, CLKS_PER_US);
            end
            last_pulse = $time;
            // count moves on the edge after the pulse
            @(negedge clk_i);
            check_flag("tsf_pulse_1m_o", tsf_pulse_1m_o, 1'b0);
            check_tsf("tsf_runtime_val_o", tsf_runtime_val_o, v + 64'(k));
        end
    endtask

    task automatic test_header_parse();
        fill_frame(2'b10);
        send_hdr_strobe();
        send_bytes(0, 3);
        wait_high(SIG_FC, 4);
        check_fc("hdr_o.fc", hdr_o.fc, 32'(field_le(0, 3)));
        send_bytes(4, 9);
        wait_high(SIG_ADDR1, 4);
        check_mac("hdr_o.addr1", hdr_o.addr1, MAC_W'(field_le(4, 9)));
        send_bytes(10, 15);
        wait_high(SIG_ADDR2, 4);
        check_mac("hdr_o.addr2", hdr_o.addr2, MAC_W'(field_le(10, 15)));
        send_bytes(16, 21);
        wait_high(SIG_ADDR3, 4);
        check_mac("hdr_o.addr3", hdr_o.addr3, MAC_W'(field_le(16, 21)));
    endtask

    // addr_kind 0 random, 1 own address, 2 broadcast
    task automatic filter_case(input logic [2:0] filt, input logic [1:0] ftype,
                               input int addr_kind, input logic exp_block);
        wb_write(REG_FILTER_CFG, 32'(filt), 4'hf);
        fill_frame(ftype);
        if (addr_kind == 1) begin
            set_addr1(own_mac);
        end else if (addr_kind == 2) begin
            set_addr1('1);
        end
        send_hdr_strobe();
        send_bytes(0, 21);
        wait_high(SIG_DECISION, 8);
        check_flag("block_rx_dma_o", block_rx_dma_o, exp_block);
    endtask

    task automatic test_filter();
        filter_case(3'b000, 2'b10, 1, 1'b0);
        filter_case(3'b000, 2'b10, 0, 1'b1);
        filter_case(3'b000, 2'b10, 2, 1'b1);
        filter_case(3'b010, 2'b10, 2, 1'b0);
        filter_case(3'b000, FC_TYPE_MGMT, 0, 1'b1);
        filter_case(3'b100, FC_TYPE_MGMT, 0, 1'b0);
        filter_case(3'b001, 2'b01, 0, 1'b0);
    endtask

    task automatic test_clearing();
        // new frame strobe wipes the old header and decision
        fill_frame(2'b10);
        send_hdr_strobe();
        send_bytes(0, 21);
        wait_high(SIG_DECISION, 8);
        send_hdr_strobe();
        check_cleared();
        // soft reset through REG_CTRL
        send_bytes(0, 21);
        wait_high(SIG_DECISION, 8);
        wb_write(REG_CTRL, 32'h1, 4'h1);
        check_cleared();
        wb_write(REG_CTRL, 32'h0, 4'h1);
        check_cleared();
        // fresh bytes bring the flags back
        send_bytes(0, 21);
        wait_high(SIG_ADDR3, 4);
        wait_high(SIG_DECISION, 4);
    endtask

    initial begin
        seed                      = 32'heaf1;
        own_mac                   = 48'h0102_3344_5566;
        git_rev_i                 = 32'h5eed_c0de;
        arst_n_i                  = 1'b0;
        wb_cyc_i                  = 1'b0;
        wb_stb_i                  = 1'b0;
        wb_we_i                   = 1'b0;
        wb_adr_i                  = '0;
        wb_dat_i                  = '0;
        wb_sel_i                  = '0;
        pkt_header_valid_strobe_i = 1'b0;
        byte_in_strobe_i          = 1'b0;
        rx_byte_i                 = '0;
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        test_registers();
        test_mac_output();
        test_tsf();
        test_header_parse();
        test_filter();
        test_clearing();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
